/* Bender.yml */
package:
  name: ao486_io

sources:
  - include_dirs:
      - include
    files:
      - src/io_pkg.sv
      - src/io_request_arbiter.sv
      - src/io_lane_planner.sv
      - src/avalon_io_master.sv
      - src/io_read_merge.sv
      - src/ao486_io.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/ao486_io_assertions.sv
      - tb/tb_ao486_io.sv

/* build.f */
+incdir+include
src/io_pkg.sv
src/io_request_arbiter.sv
src/io_lane_planner.sv
src/avalon_io_master.sv
src/io_read_merge.sv
src/ao486_io.sv
tb/ao486_io_assertions.sv
tb/tb_ao486_io.sv

/* include/io_consts.svh */
`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// --------------------
// x86 port I/O space
// --------------------

`define IO_ADDR_W 16  // port address
`define IO_DATA_W 32  // bus word and request data
`define IO_LEN_W  3   // request length of 1 to 4 bytes

// --------------------
// byte lanes
// --------------------

`define IO_BE_W   4   // lanes per bus word
`define IO_LANE_W 8   // bits per lane

`endif

/* src/ao486_io.sv */
`timescale 1ns/1ns
`default_nettype none

`include "io_consts.svh"

module ao486_io import io_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n,

    // --------------------
    // core side
    input  wire                   io_read_do,
    input  wire [`IO_ADDR_W-1:0]  io_read_address,
    input  wire [`IO_LEN_W-1:0]   io_read_length,
    output wire [`IO_DATA_W-1:0]  io_read_data,
    output wire                   io_read_done,

    input  wire                   io_write_do,
    input  wire [`IO_ADDR_W-1:0]  io_write_address,
    input  wire [`IO_LEN_W-1:0]   io_write_length,
    input  wire [`IO_DATA_W-1:0]  io_write_data,
    output wire                   io_write_done,

    input  wire                   dcache_busy,

    // --------------------
    // Avalon I/O bus
    output wire [`IO_ADDR_W-1:0]  avalon_io_address,
    output wire [`IO_BE_W-1:0]    avalon_io_byteenable,
    output wire                   avalon_io_read,
    output wire                   avalon_io_write,
    output wire [`IO_DATA_W-1:0]  avalon_io_writedata,
    input  wire                   avalon_io_waitrequest,
    input  wire                   avalon_io_readdatavalid,
    input  wire [`IO_DATA_W-1:0]  avalon_io_readdata
);

wire [`IO_ADDR_W-1:0] req_address;
wire [`IO_LEN_W-1:0]  req_length;
wire [`IO_DATA_W-1:0] req_wdata;
wire                  is_write;
wire                  start;
wire                  finish;

wire [`IO_ADDR_W-1:0] first_address;
wire [`IO_ADDR_W-1:0] second_address;
wire [`IO_BE_W-1:0]   first_be;
wire [`IO_BE_W-1:0]   second_be;
wire io_word_t        first_wdata;
wire io_word_t        second_wdata;
wire                  need_second;

wire                  word_valid;
wire                  word_index;

io_request_arbiter io_request_arbiter_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .io_read_do       (io_read_do),
    .io_read_address  (io_read_address),
    .io_read_length   (io_read_length),
    .io_write_do      (io_write_do),
    .io_write_address (io_write_address),
    .io_write_length  (io_write_length),
    .io_write_data    (io_write_data),
    .dcache_busy      (dcache_busy),
    .finish           (finish),
    .req_address      (req_address),
    .req_length       (req_length),
    .req_wdata        (req_wdata),
    .is_write         (is_write),
    .start            (start),
    .io_read_done     (io_read_done),
    .io_write_done    (io_write_done)
);

io_lane_planner io_lane_planner_inst (
    .req_address    (req_address),
    .req_length     (req_length),
    .req_wdata      (req_wdata),
    .first_address  (first_address),
    .second_address (second_address),
    .first_be       (first_be),
    .second_be      (second_be),
    .first_wdata    (first_wdata),
    .second_wdata   (second_wdata),
    .need_second    (need_second)
);

avalon_io_master avalon_io_master_inst (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .start                   (start),
    .is_write                (is_write),
    .first_address           (first_address),
    .second_address          (second_address),
    .first_be                (first_be),
    .second_be               (second_be),
    .first_wdata             (first_wdata),
    .second_wdata            (second_wdata),
    .need_second             (need_second),
    .avalon_io_address       (avalon_io_address),
    .avalon_io_byteenable    (avalon_io_byteenable),
    .avalon_io_read          (avalon_io_read),
    .avalon_io_write         (avalon_io_write),
    .avalon_io_writedata     (avalon_io_writedata),
    .avalon_io_waitrequest   (avalon_io_waitrequest),
    .avalon_io_readdatavalid (avalon_io_readdatavalid),
    .avalon_io_readdata      (avalon_io_readdata),
    .word_valid              (word_valid),
    .word_index              (word_index),
    .finish                  (finish)
);

io_read_merge io_read_merge_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .word_valid         (word_valid),
    .word_index         (word_index),
    .avalon_io_readdata (avalon_io_readdata),
    .req_address        (req_address),
    .req_length         (req_length),
    .io_read_data       (io_read_data)
);

endmodule

`default_nettype wire

/* src/avalon_io_master.sv */
`timescale 1ns/1ns
`default_nettype none

`include "io_consts.svh"

module avalon_io_master import io_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n,

    input  wire                   start,
    input  wire                   is_write,

    // planned bus cycles
    input  wire  [`IO_ADDR_W-1:0] first_address,
    input  wire  [`IO_ADDR_W-1:0] second_address,
    input  wire  [`IO_BE_W-1:0]   first_be,
    input  wire  [`IO_BE_W-1:0]   second_be,
    input  wire  io_word_t        first_wdata,
    input  wire  io_word_t        second_wdata,
    input  wire                   need_second,

    // Avalon I/O
    output logic [`IO_ADDR_W-1:0] avalon_io_address,
    output logic [`IO_BE_W-1:0]   avalon_io_byteenable,
    output logic                  avalon_io_read,
    output logic                  avalon_io_write,
    output logic [`IO_DATA_W-1:0] avalon_io_writedata,
    input  wire                   avalon_io_waitrequest,
    input  wire                   avalon_io_readdatavalid,
    input  wire  [`IO_DATA_W-1:0] avalon_io_readdata,

    // to the read merge
    output logic                  word_valid,
    output logic                  word_index,

    output logic                  finish
);

localparam logic [1:0] ST_IDLE = 2'd0;
localparam logic [1:0] ST_CMD  = 2'd1;  // strobe up until accepted
localparam logic [1:0] ST_WAIT = 2'd2;  // read accepted and waiting for data

logic [1:0] state;
logic       second_q;     // working on the second word
logic       accepted;
logic       word_done;    // current bus cycle ends this cycle
logic       more;
logic       load_first;
logic       load_second;

assign accepted    = (state == ST_CMD) && !avalon_io_waitrequest;
assign word_valid  = (state == ST_WAIT) && avalon_io_readdatavalid;
assign word_index  = second_q;
assign word_done   = (accepted && avalon_io_write) || word_valid;
assign more        = need_second && !second_q;
assign load_first  = (state == ST_IDLE) && start;
assign load_second = word_done && more;

// --------------------
// sequencing
// --------------------

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state           <= ST_IDLE;
        second_q        <= 1'b0;
        avalon_io_read  <= 1'b0;
        avalon_io_write <= 1'b0;
        finish          <= 1'b0;
    end else begin
        finish <= 1'b0;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    avalon_io_read  <= ~is_write;
                    avalon_io_write <= is_write;
                    second_q        <= 1'b0;
                    state           <= ST_CMD;
                end
            end
            ST_CMD: begin
                if (accepted) begin
                    if (avalon_io_write) begin
                        if (more) begin
                            second_q <= 1'b1;  // write stays up for the next word
                        end else begin
                            avalon_io_write <= 1'b0;
                            finish          <= 1'b1;
                            state           <= ST_IDLE;
                        end
                    end else begin
                        avalon_io_read <= 1'b0;
                        state          <= ST_WAIT;
                    end
                end
            end
            ST_WAIT: begin
                if (word_valid) begin
                    if (more) begin
                        second_q       <= 1'b1;
                        avalon_io_read <= 1'b1;
                        state          <= ST_CMD;
                    end else begin
                        finish <= 1'b1;
                        state  <= ST_IDLE;
                    end
                end
            end
            default: state <= ST_IDLE;
        endcase
    end
end

// --------------------
// command payload
// --------------------

// only changes between bus cycles, so it holds under waitrequest
always_ff @(posedge clk) begin
    if (load_first) begin
        avalon_io_address    <= first_address;
        avalon_io_byteenable <= first_be;
        avalon_io_writedata  <= first_wdata.word;
    end else if (load_second) begin
        avalon_io_address    <= second_address;
        avalon_io_byteenable <= second_be;
        avalon_io_writedata  <= second_wdata.word;
    end
end

endmodule

`default_nettype wire

/* src/io_lane_planner.sv */
`timescale 1ns/1ns
`default_nettype none

`include "io_consts.svh"

module io_lane_planner import io_pkg::*; (
    input  wire  [`IO_ADDR_W-1:0] req_address,
    input  wire  [`IO_LEN_W-1:0]  req_length,
    input  wire  [`IO_DATA_W-1:0] req_wdata,

    output logic [`IO_ADDR_W-1:0] first_address,
    output logic [`IO_ADDR_W-1:0] second_address,
    output logic [`IO_BE_W-1:0]   first_be,
    output logic [`IO_BE_W-1:0]   second_be,
    output io_word_t              first_wdata,
    output io_word_t              second_wdata,
    output logic                  need_second
);

logic [1:0]   offset;    // lane of request byte 0
logic [3:0]   end_pos;   // one past the last lane over both words
logic [3:0]   len_mask;  // n ones right aligned
logic [7:0]   span;      // enables over the two words
logic [2:0]   pos;
io_word_t     src_w;

assign offset  = req_address[1:0];
assign end_pos = {2'b00, offset} + {1'b0, req_length};

// --------------------
// addresses
// --------------------

assign first_address  = {req_address[`IO_ADDR_W-1:2], 2'b00};
assign second_address = first_address + `IO_ADDR_W'd4;  // next word
assign need_second    = end_pos > 4'd4;

// --------------------
// byte enables
// --------------------

assign len_mask  = 4'b1111 >> (3'd4 - req_length);
assign span      = {4'b0000, len_mask} << offset;
assign first_be  = span[3:0];
assign second_be = span[7:4];

// --------------------
// write lanes
// --------------------

// byte k lands on lane offset+k, spilling into the second word
always_comb begin
    src_w.word        = req_wdata;
    first_wdata.word  = '0;
    second_wdata.word = '0;
    pos               = '0;
    for (int k = 0; k < `IO_BE_W; k++) begin
        pos = {1'b0, offset} + 3'(k);
        if (k < req_length) begin
            if (pos[2]) begin
                second_wdata.lane[pos[1:0]] = src_w.lane[k];
            end else begin
                first_wdata.lane[pos[1:0]] = src_w.lane[k];
            end
        end
    end
end

endmodule

`default_nettype wire

/* src/io_pkg.sv */
`default_nettype none

`include "io_consts.svh"

package io_pkg;

    // --------------------
    // bus word
    // --------------------

    // one 32-bit word on the bus, or its four byte lanes
    // when steering write bytes and picking read bytes
    typedef union packed {
        logic [`IO_DATA_W-1:0]               word;
        logic [`IO_BE_W-1:0][`IO_LANE_W-1:0] lane;  // lane 0 is bits 7:0
    } io_word_t;

endpackage

`default_nettype wire

/* src/io_read_merge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "io_consts.svh"

module io_read_merge import io_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n,

    input  wire                   word_valid,
    input  wire                   word_index,
    input  wire  [`IO_DATA_W-1:0] avalon_io_readdata,

    input  wire  [`IO_ADDR_W-1:0] req_address,
    input  wire  [`IO_LEN_W-1:0]  req_length,

    output logic [`IO_DATA_W-1:0] io_read_data
);

io_word_t   first_q;   // first word of a split read
io_word_t   cur_w;
io_word_t   lo_w;      // word holding lanes 0..3 of the request
io_word_t   res_w;
logic [3:0] end_pos;
logic [2:0] pos;
logic       last_word;

// --------------------
// byte select
// --------------------

always_comb begin
    cur_w.word = avalon_io_readdata;
    lo_w       = word_index ? first_q : cur_w;
    end_pos    = {2'b00, req_address[1:0]} + {1'b0, req_length};
    last_word  = word_index || (end_pos <= 4'd4);  // single word when no lane is past 3
    res_w.word = '0;
    pos        = '0;
    for (int k = 0; k < `IO_BE_W; k++) begin
        pos = {1'b0, req_address[1:0]} + 3'(k);
        if (k < req_length) begin
            res_w.lane[k] = pos[2] ? cur_w.lane[pos[1:0]] : lo_w.lane[pos[1:0]];
        end
    end
end

// --------------------
// storage
// --------------------

always_ff @(posedge clk) begin
    if (word_valid && !word_index) begin
        first_q <= cur_w;
    end
end

// result only moves when a read completes
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        io_read_data <= '0;
    end else if (word_valid && last_word) begin
        io_read_data <= res_w.word;
    end
end

endmodule

`default_nettype wire

/* src/io_request_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "io_consts.svh"

module io_request_arbiter (
    input  wire                   clk,
    input  wire                   rst_n,

    input  wire                   io_read_do,
    input  wire [`IO_ADDR_W-1:0]  io_read_address,
    input  wire [`IO_LEN_W-1:0]   io_read_length,

    input  wire                   io_write_do,
    input  wire [`IO_ADDR_W-1:0]  io_write_address,
    input  wire [`IO_LEN_W-1:0]   io_write_length,
    input  wire [`IO_DATA_W-1:0]  io_write_data,

    input  wire                   dcache_busy,
    input  wire                   finish,         // bus master is through

    output logic [`IO_ADDR_W-1:0] req_address,
    output logic [`IO_LEN_W-1:0]  req_length,
    output logic [`IO_DATA_W-1:0] req_wdata,
    output logic                  is_write,
    output logic                  start,

    output logic                  io_read_done,
    output logic                  io_write_done
);

localparam logic [1:0] ST_IDLE = 2'd0;
localparam logic [1:0] ST_WAIT = 2'd1;  // request held while cache busy
localparam logic [1:0] ST_BUSY = 2'd2;  // bus cycles running
localparam logic [1:0] ST_DONE = 2'd3;  // done pulse out

logic [1:0] state;
logic       take;

assign take = (state == ST_IDLE) && (io_read_do || io_write_do);

// --------------------
// control
// --------------------

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state         <= ST_IDLE;
        is_write      <= 1'b0;
        start         <= 1'b0;
        io_read_done  <= 1'b0;
        io_write_done <= 1'b0;
    end else begin
        start         <= 1'b0;
        io_read_done  <= 1'b0;
        io_write_done <= 1'b0;
        case (state)
            ST_IDLE: begin
                if (take) begin
                    is_write <= ~io_read_do;  // read wins a tie
                    if (dcache_busy) begin
                        state <= ST_WAIT;
                    end else begin
                        start <= 1'b1;
                        state <= ST_BUSY;
                    end
                end
            end
            ST_WAIT: begin
                if (!dcache_busy) begin
                    start <= 1'b1;
                    state <= ST_BUSY;
                end
            end
            ST_BUSY: begin
                if (finish) begin
                    io_read_done  <= ~is_write;
                    io_write_done <= is_write;
                    state         <= ST_DONE;
                end
            end
            default: state <= ST_IDLE;  // done cycle then free again
        endcase
    end
end

// latched request stays stable for the planner until done
always_ff @(posedge clk) begin
    if (take) begin
        req_address <= io_read_do ? io_read_address : io_write_address;
        req_length  <= io_read_do ? io_read_length  : io_write_length;
        req_wdata   <= io_write_data;
    end
end

endmodule

`default_nettype wire

/* tb/ao486_io_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

`include "io_consts.svh"

module ao486_io_assertions (
    input wire                  clk,
    input wire                  rst_n,
    input wire                  avalon_io_read,
    input wire                  avalon_io_write,
    input wire [`IO_ADDR_W-1:0] avalon_io_address,
    input wire [`IO_BE_W-1:0]   avalon_io_byteenable,
    input wire [`IO_DATA_W-1:0] avalon_io_writedata,
    input wire                  avalon_io_waitrequest,
    input wire                  io_read_done,
    input wire                  io_write_done,
    input wire [1:0]            arb_state       // arbiter FSM state
);

localparam logic [1:0] ARB_WAIT = 2'd1;  // request held while cache busy

int fail_count = 0;

// --------------------
// bus rules
// --------------------

one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    !(avalon_io_read && avalon_io_write))
    else begin
        $error("read and write strobes are high together");
        fail_count++;
    end

cmd_held: assert property (@(posedge clk) disable iff (!rst_n)
    (avalon_io_read || avalon_io_write) && avalon_io_waitrequest |=>
        $stable(avalon_io_read) && $stable(avalon_io_write) &&
        $stable(avalon_io_address) && $stable(avalon_io_byteenable) &&
        $stable(avalon_io_writedata))
    else begin
        $error("bus command changed while waitrequest was high");
        fail_count++;
    end

// --------------------
// handshake rules
// --------------------

read_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    io_read_done |=> !io_read_done)
    else begin
        $error("io_read_done held longer than one cycle");
        fail_count++;
    end

write_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    io_write_done |=> !io_write_done)
    else begin
        $error("io_write_done held longer than one cycle");
        fail_count++;
    end

quiet_on_cache: assert property (@(posedge clk) disable iff (!rst_n)
    (arb_state == ARB_WAIT) |-> !avalon_io_read && !avalon_io_write)
    else begin
        $error("bus strobe raised while waiting on dcache_busy");
        fail_count++;
    end

endmodule

bind ao486_io ao486_io_assertions ao486_io_assertions_inst (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .avalon_io_read        (avalon_io_read),
    .avalon_io_write       (avalon_io_write),
    .avalon_io_address     (avalon_io_address),
    .avalon_io_byteenable  (avalon_io_byteenable),
    .avalon_io_writedata   (avalon_io_writedata),
    .avalon_io_waitrequest (avalon_io_waitrequest),
    .io_read_done          (io_read_done),
    .io_write_done         (io_write_done),
    .arb_state             (io_request_arbiter_inst.state)
);

`default_nettype wire

/* tb/tb_ao486_io.sv */
`timescale 1ns/1ns
`default_nettype none

`include "io_consts.svh"

module tb_ao486_io;

localparam int RAND_REQS   = 200;
localparam int REQ_CYCLES  = 15;   // worst request with full device delays
localparam int CYCLE_LIMIT = (RAND_REQS + 100) * REQ_CYCLES * 4 + 2000;
localparam int REQ_TIMEOUT = 100;

logic                  clk = 1'b0;
logic                  rst_n;
logic                  io_read_do;
logic [`IO_ADDR_W-1:0] io_read_address;
logic [`IO_LEN_W-1:0]  io_read_length;
wire  [`IO_DATA_W-1:0] io_read_data;
wire                   io_read_done;
logic                  io_write_do;
logic [`IO_ADDR_W-1:0] io_write_address;
logic [`IO_LEN_W-1:0]  io_write_length;
logic [`IO_DATA_W-1:0] io_write_data;
wire                   io_write_done;
logic                  dcache_busy;
wire  [`IO_ADDR_W-1:0] avalon_io_address;
wire  [`IO_BE_W-1:0]   avalon_io_byteenable;
wire                   avalon_io_read;
wire                   avalon_io_write;
wire  [`IO_DATA_W-1:0] avalon_io_writedata;
logic                  avalon_io_waitrequest;
logic                  avalon_io_readdatavalid;
logic [`IO_DATA_W-1:0] avalon_io_readdata;

logic [31:0] dev_mem [0:63];     // device words indexed by address[7:2]
logic [7:0]  ref_mem [0:255];    // expected device bytes
logic [15:0] cyc_addr [$];       // accepted bus cycles of one request
logic [3:0]  cyc_be [$];
logic [31:0] rd_word;
logic [5:0]  idx;
logic        rd_pending;
logic        granted;
logic        counting;
int          rd_delay;
int          wait_left;
int          seed = 32'hef1c;
int          dev_seed = 32'hef1c;
int          errors = 0;
int          err_mark = 0;
int          tests_passed = 0;
int          tests_failed = 0;
int          cycles = 0;

ao486_io u_ao486_io (.*);

always #20 clk = ~clk;

always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
        $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
        $display(">>> FAIL");
        $finish;
    end
end

// --------------------
// I/O device model
// --------------------

always @(negedge clk) begin
    avalon_io_readdatavalid = 1'b0;
    if (rd_pending) begin
        if (rd_delay == 0) begin
            avalon_io_readdatavalid = 1'b1;
            avalon_io_readdata      = rd_word;
            rd_pending              = 1'b0;
        end else begin
            rd_delay = rd_delay - 1;
        end
    end
    if (granted) begin
        granted               = 1'b0;
        avalon_io_waitrequest = 1'b1;  // taken on the last edge
    end else if (rst_n && (avalon_io_read || avalon_io_write)) begin
        if (!counting) begin
            counting  = 1'b1;
            wait_left = $unsigned($random(dev_seed)) % 4;
        end
        if (wait_left == 0) begin
            counting              = 1'b0;
            granted               = 1'b1;
            avalon_io_waitrequest = 1'b0;
            idx                   = avalon_io_address[7:2];
            cyc_addr.push_back(avalon_io_address);
            cyc_be.push_back(avalon_io_byteenable);
            if (avalon_io_write) begin
                for (int j = 0; j < 4; j++) begin
                    if (avalon_io_byteenable[j]) begin
                        dev_mem[idx][8*j +: 8] = avalon_io_writedata[8*j +: 8];
                    end
                end
            end else begin
                rd_pending = 1'b1;
                rd_delay   = $unsigned($random(dev_seed)) % 4;
                rd_word    = dev_mem[idx];
            end
        end else begin
            wait_left = wait_left - 1;
        end
    end
end

// --------------------
// expected values
// --------------------

function automatic logic [31:0] expected_read(input logic [15:0] addr, input int len);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < len; k++) begin
        r[8*k +: 8] = ref_mem[8'(addr[7:0] + 8'(k))];  // zero above the length
    end
    return r;
endfunction

function automatic logic [3:0] lane_enable(input int o, input int n, input int word);
    logic [3:0] be;
    be = '0;
    for (int lane = 0; lane < 4; lane++) begin
        be[lane] = (word == 0) ? (lane >= o && lane <= o + n - 1) : (lane <= o + n - 5);
    end
    return be;
endfunction

function automatic int error_total();
    return errors + u_ao486_io.ao486_io_assertions_inst.fail_count;
endfunction

task automatic ref_write(input logic [15:0] addr, input int len, input logic [31:0] data);
    for (int k = 0; k < len; k++) begin
        ref_mem[8'(addr[7:0] + 8'(k))] = data[8*k +: 8];
    end
endtask

task automatic check_bus(input logic [15:0] addr, input int len);
    int          o;
    int          n_cyc;
    logic [15:0] want_a;
    o     = addr[1:0];
    n_cyc = (o + len > 4) ? 2 : 1;
    assert (cyc_addr.size() == n_cyc) else begin
        $display("mismatch bus cycle count: got %h expected %h", cyc_addr.size(), n_cyc);
        errors++;
    end
    for (int i = 0; i < n_cyc && i < cyc_addr.size(); i++) begin
        want_a = {addr[15:2], 2'b00} + 16'(4 * i);
        assert (cyc_addr[i] === want_a) else begin
            $display("mismatch avalon_io_address: got %h expected %h", cyc_addr[i], want_a);
            errors++;
        end
        assert (cyc_be[i] === lane_enable(o, len, i)) else begin
            $display("mismatch avalon_io_byteenable: got %h expected %h",
                     cyc_be[i], lane_enable(o, len, i));
            errors++;
        end
    end
endtask

task automatic check_device();
    logic [31:0] want;
    for (int i = 0; i < 64; i++) begin
        want = {ref_mem[4*i+3], ref_mem[4*i+2], ref_mem[4*i+1], ref_mem[4*i]};
        assert (dev_mem[i] === want) else begin
            $display("mismatch dev_mem[%0d]: got %h expected %h", i, dev_mem[i], want);
            errors++;
        end
    end
endtask

// --------------------
// requests
// --------------------

task automatic wait_done(input bit wr, output bit seen);
    int n;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < REQ_TIMEOUT) begin
        @(negedge clk);
        seen = wr ? io_write_done : io_read_done;
        n++;
    end
endtask

// hold > 0 keeps dcache_busy high for that many cycles after do
task automatic run_request(input bit wr, input logic [15:0] addr, input int len,
                           input logic [31:0] data, input int hold);
    logic [31:0] want;
    bit          seen;
    @(negedge clk);
    want = expected_read(addr, len);
    cyc_addr.delete();
    cyc_be.delete();
    dcache_busy = (hold > 0);
    if (wr) begin
        io_write_address = addr;
        io_write_length  = 3'(len);
        io_write_data    = data;
        io_write_do      = 1'b1;
    end else begin
        io_read_address = addr;
        io_read_length  = 3'(len);
        io_read_do      = 1'b1;
    end
    repeat (hold) begin
        @(negedge clk);
        assert (!avalon_io_read && !avalon_io_write) else begin
            $display("bus strobe raised while dcache_busy is high");
            errors++;
        end
    end
    dcache_busy = 1'b0;
    wait_done(wr, seen);
    io_read_do  = 1'b0;
    io_write_do = 1'b0;
    if (wr) begin
        ref_write(addr, len, data);
    end
    if (!seen) begin
        $display("no done for request at %h within %0d cycles", addr, REQ_TIMEOUT);
        errors++;
    end else begin
        if (!wr) begin
            assert (io_read_data === want) else begin
                $display("mismatch io_read_data: got %h expected %h", io_read_data, want);
                errors++;
            end
        end
        check_bus(addr, len);
    end
endtask

task automatic end_test(input string name);
    if (error_total() == err_mark) begin
        tests_passed++;
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: failed with %0d errors", name, error_total() - err_mark);
    end
    err_mark = error_total();
endtask

// --------------------
// stimulus
// --------------------

initial begin
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] want;
    bit          seen;
    int          n;
    rst_n                   = 1'b0;
    io_read_do              = 1'b0;
    io_read_address         = '0;
    io_read_length          = 3'd1;
    io_write_do             = 1'b0;
    io_write_address        = '0;
    io_write_length         = 3'd1;
    io_write_data           = '0;
    dcache_busy             = 1'b0;
    avalon_io_waitrequest   = 1'b1;
    avalon_io_readdatavalid = 1'b0;
    avalon_io_readdata      = '0;
    rd_pending              = 1'b0;
    granted                 = 1'b0;
    counting                = 1'b0;
    for (int b = 0; b < 256; b++) begin
        ref_mem[b]                      = 8'(b * 37 + 11);  // own value per byte
        dev_mem[b / 4][8*(b % 4) +: 8] = 8'(b * 37 + 11);
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    run_request(0, 16'h0010, 1, 0, 0);
    run_request(0, 16'h0014, 2, 0, 0);
    run_request(0, 16'h0018, 4, 0, 0);
    run_request(1, 16'h0020, 1, 32'hdeadbe11, 0);
    run_request(1, 16'h0024, 2, 32'hfeed2233, 0);
    run_request(1, 16'h0028, 4, 32'h89abcdef, 0);
    run_request(0, 16'h0020, 4, 0, 0);
    run_request(0, 16'h0024, 4, 0, 0);
    end_test("1 aligned access");

    run_request(1, 16'h0033, 4, 32'h44332211, 0);
    run_request(1, 16'h0036, 4, 32'ha5b6c7d8, 0);
    run_request(1, 16'h003b, 2, 32'h00007e7f, 0);
    check_device();
    end_test("2 split write");

    run_request(0, 16'h0033, 4, 0, 0);
    run_request(0, 16'h0047, 2, 0, 0);
    run_request(0, 16'h00fe, 4, 0, 0);
    run_request(0, 16'hffff, 4, 0, 0);  // wraps to port 0
    end_test("3 split read");

    for (int i = 0; i < RAND_REQS; i++) begin
        r = $random(seed);
        d = $random(seed);
        n = (r[2:1] == 2'd0) ? 1 : (r[2:1] == 2'd1) ? 2 : 4;
        run_request(r[0], r[31:16], n, d, 0);
    end
    check_device();
    end_test("4 random requests");

    run_request(0, 16'h0062, 2, 0, 8);
    run_request(1, 16'h0063, 4, 32'hcafef00d, 5);
    run_request(0, 16'h0060, 4, 0, 0);
    end_test("5 dcache_busy hold");

    // read and write raised together on the same port
    @(negedge clk);
    want             = expected_read(16'h0050, 4);
    io_read_address  = 16'h0050;
    io_read_length   = 3'd4;
    io_write_address = 16'h0050;
    io_write_length  = 3'd4;
    io_write_data    = 32'h0badf00d;
    io_read_do       = 1'b1;
    io_write_do      = 1'b1;
    n                = 0;
    seen             = 1'b0;
    while (!seen && n < REQ_TIMEOUT) begin
        @(negedge clk);
        assert (!io_write_done) else begin
            $display("io_write_done came before io_read_done");
            errors++;
        end
        seen = io_read_done;
        n++;
    end
    io_read_do = 1'b0;
    if (!seen) begin
        $display("no io_read_done for the tied request");
        errors++;
    end
    assert (io_read_data === want) else begin
        $display("mismatch io_read_data: got %h expected %h", io_read_data, want);
        errors++;
    end
    wait_done(1'b1, seen);
    io_write_do = 1'b0;
    if (!seen) begin
        $display("no io_write_done for the tied request");
        errors++;
    end
    ref_write(16'h0050, 4, 32'h0badf00d);
    run_request(0, 16'h0050, 4, 0, 0);
    end_test("6 read wins a tie");

    $display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed,
             error_total());
    if (tests_failed == 0 && error_total() == 0) begin
        $display(">>> PASS");
    end else begin
        $display(">>> FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire
